/* rtl/rsa_settings.svh */
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

`define RSA_WIDTH 256                   // Operand width.
`define RSA_STEP_BITS 9                 // Counts past RSA_WIDTH.

`define RSA_PREP_ITERS `RSA_WIDTH       // Doublings into the Montgomery domain.
`define RSA_MONT_ITERS (`RSA_WIDTH + 1) // Halvings plus the final reduction.

`endif

/* rtl/rsa_pkg.sv */
`include "rsa_settings.svh"

package rsa_pkg;

	typedef logic [`RSA_WIDTH-1:0] rsa_word_t;

	typedef struct packed {
		rsa_word_t msg; // Cipher text.
		rsa_word_t key; // Private exponent.
		rsa_word_t n;   // Modulus, odd.
	} rsa_req_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PREP,
		ST_STEP,
		ST_UPDATE
	} rsa_state_e;

endpackage

/* rtl/rsa_prep.sv */
`include "rsa_settings.svh"

module rsa_prep
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_msg,
	input  rsa_word_t i_n,
	output rsa_word_t o_result,
	output logic      o_done
);

	localparam logic [`RSA_STEP_BITS-1:0] LAST_CNT = `RSA_STEP_BITS'(`RSA_PREP_ITERS);

	logic                      busy;
	logic [`RSA_STEP_BITS-1:0] cnt;
	rsa_word_t                 val;
	logic [`RSA_WIDTH:0]       dbl;     // One bit of headroom.
	logic [`RSA_WIDTH:0]       dbl_red;

	assign dbl      = {val, 1'b0};
	assign dbl_red  = (dbl >= {1'b0, i_n}) ? dbl - {1'b0, i_n} : dbl;
	assign o_result = val;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy   <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (!busy) begin
				if (i_start) begin
					busy <= 1'b1;
					cnt  <= '0;
				end
			end else if (cnt == LAST_CNT) begin
				busy   <= 1'b0; // Extra cycle raises done.
				o_done <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Value stays below N, so one subtraction per doubling is enough.
	always_ff @(posedge i_clk) begin
		if (!busy && i_start) begin
			val <= i_msg;
		end else if (busy && cnt != LAST_CNT) begin
			val <= dbl_red[`RSA_WIDTH-1:0];
		end
	end

	assert property (@(posedge i_clk) disable iff (i_rst) busy |-> !i_start)
		else $error("rsa_prep: start while busy.");

endmodule

/* rtl/rsa_mont.sv */
`include "rsa_settings.svh"

module rsa_mont
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_a,
	input  rsa_word_t i_b,
	input  rsa_word_t i_n,
	output rsa_word_t o_result,
	output logic      o_done
);

	localparam logic [`RSA_STEP_BITS-1:0] REDUCE_CNT = `RSA_STEP_BITS'(`RSA_WIDTH);
	localparam logic [`RSA_STEP_BITS-1:0] LAST_CNT   = `RSA_STEP_BITS'(`RSA_MONT_ITERS);

	logic                      busy;
	logic [`RSA_STEP_BITS-1:0] cnt;
	rsa_word_t                 a_sr;    // Multiplier bits, LSB first.
	logic [`RSA_WIDTH+1:0]     sum;     // Stays below 2N.
	logic [`RSA_WIDTH+1:0]     n_ext;
	logic [`RSA_WIDTH+1:0]     sum_b;
	logic [`RSA_WIDTH+1:0]     sum_n;
	logic [`RSA_WIDTH+1:0]     sum_red;

	assign n_ext   = {2'b00, i_n};
	assign sum_b   = a_sr[0] ? sum + {2'b00, i_b} : sum;
	assign sum_n   = sum_b[0] ? sum_b + n_ext : sum_b; // Make it even.
	assign sum_red = (sum >= n_ext) ? sum - n_ext : sum;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy   <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (!busy) begin
				if (i_start) begin
					busy <= 1'b1;
					cnt  <= '0;
				end
			end else if (cnt == LAST_CNT) begin
				busy   <= 1'b0;
				o_done <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// b and N are held by the caller for the whole run.
	always_ff @(posedge i_clk) begin
		if (!busy) begin
			if (i_start) begin
				a_sr <= i_a;
				sum  <= '0;
			end
		end else if (cnt < REDUCE_CNT) begin
			a_sr <= a_sr >> 1;
			sum  <= {1'b0, sum_n[`RSA_WIDTH+1:1]};
		end else if (cnt == REDUCE_CNT) begin
			o_result <= sum_red[`RSA_WIDTH-1:0];
		end
	end

	assert property (@(posedge i_clk) disable iff (i_rst) busy |-> !i_start)
		else $error("rsa_mont: start while busy.");

endmodule

/* rtl/rsa_exp_scanner.sv */
`include "rsa_settings.svh"

module rsa_exp_scanner
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_load,
	input  rsa_word_t i_key,
	input  logic      i_advance,
	output logic      o_bit,
	output logic      o_last
);

	localparam logic [`RSA_STEP_BITS-1:0] LAST_STEP = `RSA_STEP_BITS'(`RSA_WIDTH - 1);

	rsa_word_t                 key_sr;
	logic [`RSA_STEP_BITS-1:0] step;

	assign o_bit  = key_sr[0];
	assign o_last = (step == LAST_STEP);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			step <= '0;
		end else if (i_load) begin
			step <= '0;
		end else if (i_advance) begin
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			key_sr <= i_key;
		end else if (i_advance) begin
			key_sr <= key_sr >> 1; // Next exponent bit.
		end
	end

endmodule

/* rtl/rsa_exp_ctrl.sv */
module rsa_exp_ctrl
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_req_t  i_req,
	input  logic      i_bit,
	input  logic      i_last,
	input  rsa_word_t i_prep_result,
	input  rsa_word_t i_sqr_result,
	input  rsa_word_t i_mul_result,
	input  logic      i_prep_done,
	input  logic      i_sqr_done,
	output logic      o_prep_start,
	output logic      o_sqr_start,
	output logic      o_mul_start,
	output logic      o_scan_load,
	output logic      o_scan_advance,
	output rsa_word_t o_power,
	output rsa_word_t o_ans,
	output rsa_word_t o_n,
	output logic      o_finished
);

	rsa_state_e state;
	logic       issue; // First cycle of a step.

	assign o_scan_load    = (state == ST_IDLE) && i_start;
	assign o_scan_advance = (state == ST_UPDATE);
	assign o_sqr_start    = issue;
	assign o_mul_start    = issue && i_bit;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state        <= ST_IDLE;
			issue        <= 1'b0;
			o_prep_start <= 1'b0;
			o_finished   <= 1'b0;
			o_ans        <= '0;
		end else begin
			issue        <= 1'b0;
			o_prep_start <= 1'b0;
			o_finished   <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state        <= ST_PREP;
						o_prep_start <= 1'b1;
						o_ans        <= rsa_word_t'(1); // Plain 1, not Montgomery.
					end
				end
				ST_PREP: begin
					if (i_prep_done) begin
						state <= ST_STEP;
						issue <= 1'b1;
					end
				end
				ST_STEP: begin
					if (i_sqr_done) begin
						state <= ST_UPDATE; // Multiply finishes in the same cycle.
					end
				end
				ST_UPDATE: begin
					if (i_bit) begin
						o_ans <= i_mul_result;
					end
					if (i_last) begin
						state      <= ST_IDLE;
						o_finished <= 1'b1;
					end else begin
						state <= ST_STEP;
						issue <= 1'b1; // Scanner bit is fresh by then.
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Power also holds the message until prep has sampled it.
	always_ff @(posedge i_clk) begin
		if (o_scan_load) begin
			o_power <= i_req.msg;
			o_n     <= i_req.n;
		end else if (state == ST_PREP && i_prep_done) begin
			o_power <= i_prep_result;
		end else if (state == ST_UPDATE) begin
			o_power <= i_sqr_result;
		end
	end

	assert property (@(posedge i_clk) disable iff (i_rst) i_prep_done |-> state == ST_PREP)
		else $error("rsa_exp_ctrl: prep done outside the prep state.");

	assert property (@(posedge i_clk) disable iff (i_rst) i_sqr_done |-> state == ST_STEP)
		else $error("rsa_exp_ctrl: square done outside a step.");

endmodule

/* rtl/rsa256_core.sv */
module rsa256_core
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_req_t  i_req,
	output rsa_word_t o_ans,
	output logic      o_finished
);

	logic      scan_bit;
	logic      scan_last;
	logic      scan_load;
	logic      scan_advance;
	logic      prep_start;
	logic      prep_done;
	logic      sqr_start;
	logic      sqr_done;
	logic      mul_start;
	rsa_word_t prep_result;
	rsa_word_t sqr_result;
	rsa_word_t mul_result;
	rsa_word_t power;
	rsa_word_t n;

	rsa_exp_ctrl ctrl (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.i_req          (i_req),
		.i_bit          (scan_bit),
		.i_last         (scan_last),
		.i_prep_result  (prep_result),
		.i_sqr_result   (sqr_result),
		.i_mul_result   (mul_result),
		.i_prep_done    (prep_done),
		.i_sqr_done     (sqr_done),
		.o_prep_start   (prep_start),
		.o_sqr_start    (sqr_start),
		.o_mul_start    (mul_start),
		.o_scan_load    (scan_load),
		.o_scan_advance (scan_advance),
		.o_power        (power),
		.o_ans          (o_ans),
		.o_n            (n),
		.o_finished     (o_finished)
	);

	rsa_exp_scanner scanner (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_load    (scan_load),
		.i_key     (i_req.key),
		.i_advance (scan_advance),
		.o_bit     (scan_bit),
		.o_last    (scan_last)
	);

	rsa_prep prep (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (prep_start),
		.i_msg    (power),
		.i_n      (n),
		.o_result (prep_result),
		.o_done   (prep_done)
	);

	rsa_mont mont_sqr (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (sqr_start),
		.i_a      (power),
		.i_b      (power),
		.i_n      (n),
		.o_result (sqr_result),
		.o_done   (sqr_done)
	);

	rsa_mont mont_mul (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mul_start),
		.i_a      (o_ans),
		.i_b      (power),
		.i_n      (n),
		.o_result (mul_result),
		.o_done   ()            // Same latency as mont_sqr.
	);

endmodule

/* tests/tb_rsa256_core.sv */
`include "rsa_settings.svh"

module tb_rsa256_core
	import rsa_pkg::*;
();

	localparam int        NUM_REQ       = 17;
	localparam int        NUM_RANDOM    = 10;
	localparam longint    WATCHDOG_TIME = longint'(NUM_REQ) * 70000 * 100; // Cycles times period.
	localparam bit [31:0] SEED          = 32'ha1ce_ce87;

	logic      i_clk;
	logic      i_rst;
	logic      i_start;
	rsa_req_t  i_req;
	rsa_word_t o_ans;
	logic      o_finished;

	rsa_word_t exp_q[$];     // Expected answers in issue order.
	int        issued = 0;
	int        finish_cnt = 0;

	rsa256_core uut (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_req      (i_req),
		.o_ans      (o_ans),
		.o_finished (o_finished)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped.");
	endtask

	task automatic check_ans(string what, rsa_word_t exp, rsa_word_t act);
		if (act !== exp) begin
			$display("ERR %0t: %s expected %h got %h", $time, what, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_flag(string what, logic exp, logic act);
		if (act !== exp) begin
			$display("ERR %0t: %s expected %b got %b", $time, what, exp, act);
			abort_run();
		end
	endtask

	function automatic rsa_word_t mod_mul(rsa_word_t a, rsa_word_t b, rsa_word_t n);
		logic [2*`RSA_WIDTH-1:0] prod;
		prod = {{`RSA_WIDTH{1'b0}}, a} * {{`RSA_WIDTH{1'b0}}, b};
		prod = prod % {{`RSA_WIDTH{1'b0}}, n}; // Full double-width product.
		return prod[`RSA_WIDTH-1:0];
	endfunction

	// Square and multiply, key LSB first.
	function automatic rsa_word_t ref_modexp(rsa_word_t msg, rsa_word_t key, rsa_word_t n);
		rsa_word_t res;
		rsa_word_t pw;
		res = rsa_word_t'(1) % n;
		pw  = msg % n;
		for (int i = 0; i < `RSA_WIDTH; i++) begin
			if (key[i]) begin
				res = mod_mul(res, pw, n);
			end
			pw = mod_mul(pw, pw, n);
		end
		return res;
	endfunction

	function automatic rsa_word_t rand_word();
		rsa_word_t w;
		for (int k = 0; k < `RSA_WIDTH / 32; k++) begin
			w[32*k +: 32] = $urandom;
		end
		return w;
	endfunction

	function automatic rsa_word_t rand_odd_word();
		rsa_word_t w;
		w    = rand_word();
		w[0] = 1'b1; // Modulus must be odd.
		return w;
	endfunction

	task automatic issue_request(rsa_word_t msg, rsa_word_t key, rsa_word_t n);
		@(negedge i_clk);
		i_req.msg = msg;
		i_req.key = key;
		i_req.n   = n;
		i_start   = 1'b1;
		exp_q.push_back(ref_modexp(msg, key, n));
		issued++;
		@(negedge i_clk);
		i_start = 1'b0;
	endtask

	// Start strobe that the busy core must drop.
	task automatic drop_start(rsa_word_t msg, rsa_word_t key, rsa_word_t n);
		@(negedge i_clk);
		i_req.msg = msg;
		i_req.key = key;
		i_req.n   = n;
		i_start   = 1'b1;
		@(negedge i_clk);
		i_start = 1'b0;
	endtask

	task automatic wait_finished();
		wait (finish_cnt == issued);
	endtask

	task automatic run_request(rsa_word_t msg, rsa_word_t key, rsa_word_t n);
		issue_request(msg, key, n);
		wait_finished();
	endtask

	initial begin : compare_results
		forever begin
			@(negedge i_clk);
			if (!i_rst && o_finished) begin
				if (exp_q.size() == 0) begin
					$display("o_finished pulsed at time %0t with no request pending.", $time);
					abort_run();
				end else begin
					check_ans("o_ans", exp_q.pop_front(), o_ans);
					finish_cnt++;
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		$display("Timeout: o_finished never came within %0d time units.", WATCHDOG_TIME);
		abort_run();
	end

	initial begin : stimulus
		rsa_word_t n;
		rsa_word_t msg;
		rsa_word_t key;
		void'($urandom(SEED));
		i_rst   = 1'b1;
		i_start = 1'b0;
		i_req   = '0;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		repeat (4) begin
			@(negedge i_clk);
			compare_flag("o_finished before start", 1'b0, o_finished);
			check_ans("o_ans before start", '0, o_ans);
		end
		check_ans("reference vector", rsa_word_t'(123),
			ref_modexp(rsa_word_t'(855), rsa_word_t'(2753), rsa_word_t'(3233)));

		run_request(rsa_word_t'(855), '0, rsa_word_t'(3233)); // Key zero gives 1.
		n   = rand_odd_word();
		msg = rand_word() % n;
		run_request(msg, rsa_word_t'(1), n);
		run_request(rsa_word_t'(855), rsa_word_t'(2753), rsa_word_t'(3233));
		run_request(rsa_word_t'(42), rsa_word_t'(7), rsa_word_t'(253));

		repeat (NUM_RANDOM) begin
			n   = rand_odd_word();
			msg = rand_word() % n;
			key = rand_word();
			run_request(msg, key, n);
		end

		n   = rand_odd_word();
		msg = rand_word() % n;
		issue_request(msg, rand_word(), n);
		repeat (3000) @(negedge i_clk);
		drop_start(rsa_word_t'(855), rsa_word_t'(2753), rsa_word_t'(3233));
		wait_finished();

		n = rand_odd_word();
		run_request(rand_word() % n, rand_word(), n);
		issue_request(rsa_word_t'(855), rsa_word_t'(17), rsa_word_t'(3233)); // Cycle after finish.
		wait_finished();

		repeat (10) @(negedge i_clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* flist.f */
+incdir+rtl
rtl/rsa_pkg.sv
rtl/rsa_prep.sv
rtl/rsa_mont.sv
rtl/rsa_exp_scanner.sv
rtl/rsa_exp_ctrl.sv
rtl/rsa256_core.sv
tests/tb_rsa256_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rsa256_core \
	-Mdir obj_dir -o sim_rsa256 -f flist.f
./obj_dir/sim_rsa256 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Testbench reported a failure."
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a result."
	exit 1
fi
echo "Testbench passed."
